// File: common/cart_pkg.sv
////////////////////////////////////////////////////////////////////////////
// ROM download types and header map
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package cart_pkg;

	typedef logic [24:0] dl_addr_t;       // Byte address of a download word
	typedef logic [15:0] dl_word_t;       // One download word
	typedef logic [3:0]  eeprom_map_t;
	typedef logic [2:0]  sf_map_t;        // Bootleg bank mapping
	typedef logic [7:0]  sensor_delay_t;  // Light-gun delay in pixels

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	// Region priority orders
	typedef logic [1:0] region_prio_t;
	localparam region_prio_t PRIO_US_EU_JP = 2'd0;
	localparam region_prio_t PRIO_EU_US_JP = 2'd1;
	localparam region_prio_t PRIO_US_JP_EU = 2'd2;
	localparam region_prio_t PRIO_JP_US_EU = 2'd3;

	// Header words strobed during a ROM download
	typedef enum logic [3:0] {
		NONE, ID0, ID1, ID2, ID3, ID4, ID5, CRC, ID_DONE, RGN0, RGN1, HDR_END
	} hdr_field_t;

	localparam dl_addr_t ADDR_ID0     = 25'h180;  // Serial string start
	localparam dl_addr_t ADDR_ID1     = 25'h182;
	localparam dl_addr_t ADDR_ID2     = 25'h184;
	localparam dl_addr_t ADDR_ID3     = 25'h186;
	localparam dl_addr_t ADDR_ID4     = 25'h188;
	localparam dl_addr_t ADDR_ID5     = 25'h18A;
	localparam dl_addr_t ADDR_CRC     = 25'h18E;
	localparam dl_addr_t ADDR_ID_DONE = 25'h190;  // First word past the serial
	localparam dl_addr_t ADDR_RGN0    = 25'h1F0;
	localparam dl_addr_t ADDR_RGN1    = 25'h1F2;
	localparam dl_addr_t ADDR_HDR_END = 25'h200;

	// Download index of cheat-code files
	localparam logic [7:0] CODE_INDEX = 8'hFF;

endpackage

`default_nettype wire

// File: common/cheat_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Cheat-code record layout
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package cheat_pkg;

	typedef logic [31:0] cheat_word_t;    // One 32-bit field of a code
	typedef logic [3:0]  cheat_offset_t;  // Byte offset within a record

	// Word offsets in the 16-byte record, low word first
	localparam cheat_offset_t OFS_FLAGS_LO = 4'd0;
	localparam cheat_offset_t OFS_FLAGS_HI = 4'd2;
	localparam cheat_offset_t OFS_ADDR_LO  = 4'd4;
	localparam cheat_offset_t OFS_ADDR_HI  = 4'd6;
	localparam cheat_offset_t OFS_CMP_LO   = 4'd8;
	localparam cheat_offset_t OFS_CMP_HI   = 4'd10;
	localparam cheat_offset_t OFS_RPL_LO   = 4'd12;
	localparam cheat_offset_t OFS_RPL_HI   = 4'd14;  // Last word of a record

endpackage

`default_nettype wire

// File: design/dl_capture.sv
////////////////////////////////////////////////////////////////////////////
// Download stream capture
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dl_capture (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  logic                     dl_active,
	input  logic [7:0]               dl_index,
	input  logic                     dl_wr,
	input  cart_pkg::dl_addr_t       dl_addr,
	input  cart_pkg::dl_word_t       dl_data,
	output logic                     rom_start,
	output logic                     rom_end,
	output cart_pkg::dl_addr_t       rom_size,
	output cart_pkg::hdr_field_t     hdr_field,
	output cart_pkg::dl_word_t       hdr_word,
	output logic                     code_wr,
	output cheat_pkg::cheat_offset_t code_offset,
	output cart_pkg::dl_word_t       code_word
);
	import cart_pkg::*;

	logic       code_dl;
	logic       rom_dl;
	logic       rom_dl_d;   // Previous rom_dl for edge detection
	dl_addr_t   last_addr;  // Last ROM write address
	hdr_field_t field_sel;

	assign code_dl = dl_active && (dl_index == CODE_INDEX);
	assign rom_dl  = dl_active && (dl_index != CODE_INDEX);

	// Header address decode
	always_comb begin
		case (dl_addr)
			ADDR_ID0:     field_sel = ID0;
			ADDR_ID1:     field_sel = ID1;
			ADDR_ID2:     field_sel = ID2;
			ADDR_ID3:     field_sel = ID3;
			ADDR_ID4:     field_sel = ID4;
			ADDR_ID5:     field_sel = ID5;
			ADDR_CRC:     field_sel = CRC;
			ADDR_ID_DONE: field_sel = ID_DONE;
			ADDR_RGN0:    field_sel = RGN0;
			ADDR_RGN1:    field_sel = RGN1;
			ADDR_HDR_END: field_sel = HDR_END;
			default:      field_sel = NONE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_dl_d  <= 1'b0;
			rom_start <= 1'b0;
			rom_end   <= 1'b0;
			rom_size  <= '0;
			last_addr <= '0;
			hdr_field <= NONE;
			code_wr   <= 1'b0;
		end else begin
			rom_dl_d  <= rom_dl;
			rom_start <= rom_dl && !rom_dl_d;
			rom_end   <= !rom_dl && rom_dl_d;
			if (rom_dl && !rom_dl_d)
				last_addr <= '0;
			if (rom_dl && dl_wr)
				last_addr <= dl_addr;
			if (!rom_dl && rom_dl_d)
				rom_size <= last_addr;  // Download just ended
			hdr_field <= (rom_dl && dl_wr) ? field_sel : NONE;
			code_wr   <= code_dl && dl_wr;
		end
	end

	// Data path, header words turned big-endian
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			hdr_word    <= {dl_data[7:0], dl_data[15:8]};
			code_offset <= dl_addr[3:0];
			code_word   <= dl_data;
		end
	end

endmodule

`default_nettype wire

// File: header/region_decode.sv
////////////////////////////////////////////////////////////////////////////
// Cartridge region decode and selection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module region_decode (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   rom_start,
	input  logic                   rom_end,
	input  cart_pkg::hdr_field_t   hdr_field,
	input  cart_pkg::dl_word_t     hdr_word,
	input  cart_pkg::region_prio_t region_prio,
	input  logic                   auto_region_en,
	output cart_pkg::region_t      region_req,
	output logic                   region_set
);
	import cart_pkg::*;

	logic       hdr_j;
	logic       hdr_u;
	logic       hdr_e;
	logic       nxt_j;
	logic       nxt_u;
	logic       nxt_e;
	logic       hdr_ready;
	logic       hdr_ready_d;
	logic [7:0] byte_a;   // Byte at the even address
	logic [7:0] byte_b;   // Byte at the odd address
	logic [3:0] hex_adj;  // Hex letter A-F moved down to 10-15
	region_t    pick;

	assign byte_a  = hdr_word[15:8];
	assign byte_b  = hdr_word[7:0];
	assign hex_adj = byte_a[3:0] - 4'd7;

	////////////////////////////////////////////////////////////////////////////
	// Region flags from the header characters

	always_comb begin
		{nxt_e, nxt_u, nxt_j} = {hdr_e, hdr_u, hdr_j};
		if (hdr_field == RGN0 || hdr_field == RGN1) begin
			if (byte_a == "J")
				nxt_j = 1'b1;
			else if (byte_a == "U")
				nxt_u = 1'b1;
			else if (byte_a == "E")
				nxt_e = 1'b1;
			else if (hdr_field == RGN0 && byte_a >= "0" && byte_a <= "9")
				{nxt_e, nxt_u, nxt_j} = {byte_a[3], byte_a[2], byte_a[0]};
			else if (hdr_field == RGN0 && byte_a >= "A" && byte_a <= "F")
				{nxt_e, nxt_u, nxt_j} = {hex_adj[3], hex_adj[2], hex_adj[0]};

			// Second character of the old style field
			if (hdr_field == RGN0) begin
				if (byte_b == "J")
					nxt_j = 1'b1;
				else if (byte_b == "U")
					nxt_u = 1'b1;
				else if (byte_b == "E")
					nxt_e = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Priority choice, the order's first entry when nothing is flagged

	always_comb begin
		case (region_prio)
			PRIO_US_EU_JP: pick = hdr_u ? US : hdr_e ? EU : hdr_j ? JP : US;
			PRIO_EU_US_JP: pick = hdr_e ? EU : hdr_u ? US : hdr_j ? JP : EU;
			PRIO_US_JP_EU: pick = hdr_u ? US : hdr_j ? JP : hdr_e ? EU : US;
			PRIO_JP_US_EU: pick = hdr_j ? JP : hdr_u ? US : hdr_e ? EU : JP;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			{hdr_e, hdr_u, hdr_j} <= 3'b000;
			hdr_ready   <= 1'b0;
			hdr_ready_d <= 1'b0;
			region_set  <= 1'b0;
			region_req  <= JP;
		end else begin
			if (rom_start)
				{hdr_e, hdr_u, hdr_j} <= 3'b000;
			else
				{hdr_e, hdr_u, hdr_j} <= {nxt_e, nxt_u, nxt_j};

			if (rom_end)
				hdr_ready <= 1'b0;
			else if (hdr_field == HDR_END)
				hdr_ready <= 1'b1;  // Whole header seen
			hdr_ready_d <= hdr_ready;

			if (hdr_ready && !hdr_ready_d && auto_region_en) begin
				region_req <= pick;
				region_set <= 1'b1;
			end
			if (!hdr_ready && hdr_ready_d)
				region_set <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: header/cart_id_match.sv
////////////////////////////////////////////////////////////////////////////
// Cartridge serial match and quirk lookup
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cart_id_match #(
	parameter cart_pkg::sensor_delay_t DEFAULT_SENSOR_DELAY = 8'd44
) (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    rom_start,
	input  cart_pkg::hdr_field_t    hdr_field,
	input  cart_pkg::dl_word_t      hdr_word,
	output cart_pkg::eeprom_map_t   eeprom_map,
	output cart_pkg::sf_map_t       sf_map,
	output logic                    gun_type,
	output cart_pkg::sensor_delay_t gun_sensor_delay
);
	import cart_pkg::*;

	// Serial numbers, product code part of the string
	localparam logic [63:0] SER_EEP_MAP1 = "T-50446 ";
	localparam logic [63:0] SER_EEP_MAP2 = "MK-1215 ";
	localparam logic [63:0] SER_EEP_MAP3 = "T-081326";
	localparam logic [63:0] SER_GUN_FAST = "T-95096-";  // Second gun type
	localparam logic [63:0] SER_GUN_SLOW = "MK-1533 ";

	// Bootleg cartridges, start of the string
	localparam logic [47:0] SER_SF_001 = "SF-001";
	localparam logic [47:0] SER_SF_002 = "SF-002";
	localparam dl_word_t    CRC_SF_REV = 16'h3E08;

	localparam sensor_delay_t DELAY_GUN_FAST = 8'd52;
	localparam sensor_delay_t DELAY_GUN_SLOW = 8'd100;

	logic [87:0] cart_id;  // 11 serial characters, first one on top
	dl_word_t    crc;
	logic [63:0] id_tail;
	logic [47:0] id_head;

	assign id_tail = cart_id[63:0];
	assign id_head = cart_id[87:40];

	////////////////////////////////////////////////////////////////////////////
	// Serial and checksum assembly

	always_ff @(posedge clk_sys) begin
		case (hdr_field)
			ID0:     cart_id[87:72] <= hdr_word;
			ID1:     cart_id[71:56] <= hdr_word;
			ID2:     cart_id[55:40] <= hdr_word;
			ID3:     cart_id[39:24] <= hdr_word;
			ID4:     cart_id[23:8]  <= hdr_word;
			ID5:     cart_id[7:0]   <= hdr_word[15:8];  // 11th character only
			CRC:     crc            <= hdr_word;
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Quirk table

	always_ff @(posedge clk_sys) begin
		if (RESET || rom_start) begin
			eeprom_map       <= '0;
			sf_map           <= '0;
			gun_type         <= 1'b0;
			gun_sensor_delay <= DEFAULT_SENSOR_DELAY;
		end else if (hdr_field == ID_DONE) begin
			if (id_tail == SER_EEP_MAP1)
				eeprom_map <= 4'd1;
			else if (id_tail == SER_EEP_MAP2)
				eeprom_map <= 4'd2;
			else if (id_tail == SER_EEP_MAP3)
				eeprom_map <= 4'd3;
			else if (id_head == SER_SF_001)
				sf_map <= {crc == CRC_SF_REV, 2'b01};  // Top bit marks the later revision
			else if (id_head == SER_SF_002)
				sf_map <= {1'b1, 2'b10};

			// Light-gun type and sensor timing
			if (id_tail == SER_GUN_FAST) begin
				gun_type         <= 1'b1;
				gun_sensor_delay <= DELAY_GUN_FAST;
			end else if (id_tail == SER_GUN_SLOW) begin
				gun_type         <= 1'b0;
				gun_sensor_delay <= DELAY_GUN_SLOW;
			end else begin
				gun_type         <= 1'b0;
				gun_sensor_delay <= DEFAULT_SENSOR_DELAY;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/cheat_loader.sv
////////////////////////////////////////////////////////////////////////////
// Cheat-code record loader
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cheat_loader (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  logic                     code_wr,
	input  cheat_pkg::cheat_offset_t code_offset,
	input  cart_pkg::dl_word_t       code_word,
	output logic                     code_clear,
	output logic                     code_valid,
	output cheat_pkg::cheat_word_t   code_flags,
	output cheat_pkg::cheat_word_t   code_addr,
	output cheat_pkg::cheat_word_t   code_compare,
	output cheat_pkg::cheat_word_t   code_replace
);
	import cheat_pkg::*;

	logic rec_first;  // Still in the first record after reset
	logic rec_last;   // Word completes a record

	assign rec_last = code_wr && (code_offset == OFS_RPL_HI);

	// Record fields, low word first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (code_offset)
				OFS_FLAGS_LO: code_flags[15:0]    <= code_word;
				OFS_FLAGS_HI: code_flags[31:16]   <= code_word;
				OFS_ADDR_LO:  code_addr[15:0]     <= code_word;
				OFS_ADDR_HI:  code_addr[31:16]    <= code_word;
				OFS_CMP_LO:   code_compare[15:0]  <= code_word;
				OFS_CMP_HI:   code_compare[31:16] <= code_word;
				OFS_RPL_LO:   code_replace[15:0]  <= code_word;
				OFS_RPL_HI:   code_replace[31:16] <= code_word;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
			code_clear <= 1'b0;
			rec_first  <= 1'b1;
		end else begin
			code_valid <= rec_last && !code_addr[31];  // Bit 31 marks a disabled code
			code_clear <= code_wr && (code_offset == OFS_FLAGS_LO) && rec_first;
			if (rec_last)
				rec_first <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: design/cart_header_top.sv
////////////////////////////////////////////////////////////////////////////
// Cartridge header inspection top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cart_header_top #(
	parameter cart_pkg::sensor_delay_t DEFAULT_SENSOR_DELAY = 8'd44
) (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    dl_active,
	input  logic [7:0]              dl_index,
	input  logic                    dl_wr,
	input  cart_pkg::dl_addr_t      dl_addr,
	input  cart_pkg::dl_word_t      dl_data,
	input  cart_pkg::region_prio_t  region_prio,
	input  logic                    auto_region_en,
	output cart_pkg::region_t       region_req,
	output logic                    region_set,
	output cart_pkg::dl_addr_t      rom_size,
	output cart_pkg::eeprom_map_t   eeprom_map,
	output cart_pkg::sf_map_t       sf_map,
	output logic                    gun_type,
	output cart_pkg::sensor_delay_t gun_sensor_delay,
	output logic                    code_clear,
	output logic                    code_valid,
	output cheat_pkg::cheat_word_t  code_flags,
	output cheat_pkg::cheat_word_t  code_addr,
	output cheat_pkg::cheat_word_t  code_compare,
	output cheat_pkg::cheat_word_t  code_replace
);
	import cart_pkg::*;
	import cheat_pkg::*;

	logic          rom_start;
	logic          rom_end;
	hdr_field_t    hdr_field;
	dl_word_t      hdr_word;   // Big-endian header word
	logic          code_wr;
	cheat_offset_t code_offset;
	dl_word_t      code_word;

	dl_capture i_capture (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.rom_start   (rom_start),
		.rom_end     (rom_end),
		.rom_size    (rom_size),
		.hdr_field   (hdr_field),
		.hdr_word    (hdr_word),
		.code_wr     (code_wr),
		.code_offset (code_offset),
		.code_word   (code_word)
	);

	region_decode i_region (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.rom_start      (rom_start),
		.rom_end        (rom_end),
		.hdr_field      (hdr_field),
		.hdr_word       (hdr_word),
		.region_prio    (region_prio),
		.auto_region_en (auto_region_en),
		.region_req     (region_req),
		.region_set     (region_set)
	);

	cart_id_match #(
		.DEFAULT_SENSOR_DELAY (DEFAULT_SENSOR_DELAY)
	) i_cart_id (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.rom_start        (rom_start),
		.hdr_field        (hdr_field),
		.hdr_word         (hdr_word),
		.eeprom_map       (eeprom_map),
		.sf_map           (sf_map),
		.gun_type         (gun_type),
		.gun_sensor_delay (gun_sensor_delay)
	);

	cheat_loader i_cheat (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.code_wr      (code_wr),
		.code_offset  (code_offset),
		.code_word    (code_word),
		.code_clear   (code_clear),
		.code_valid   (code_valid),
		.code_flags   (code_flags),
		.code_addr    (code_addr),
		.code_compare (code_compare),
		.code_replace (code_replace)
	);

endmodule

`default_nettype wire

// File: dv/cart_header_props.sv
////////////////////////////////////////////////////////////////////////////
// Cartridge header timing properties
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cart_header_props #(
	parameter cart_pkg::sensor_delay_t DEFAULT_SENSOR_DELAY = 8'd44
) (
	input logic                    clk_sys,
	input logic                    RESET,
	input logic                    dl_active,
	input logic [7:0]              dl_index,
	input logic                    dl_wr,
	input cart_pkg::dl_addr_t      dl_addr,
	input logic                    auto_region_en,
	input logic                    region_set,
	input cart_pkg::dl_addr_t      rom_size,
	input cart_pkg::eeprom_map_t   eeprom_map,
	input cart_pkg::sf_map_t       sf_map,
	input logic                    gun_type,
	input cart_pkg::sensor_delay_t gun_sensor_delay,
	input logic                    code_clear,
	input logic                    code_valid
);
	import cart_pkg::*;

	int   violations = 0;  // Read by the testbench at the end
	logic rom_dl;
	logic rom_dl_q;
	logic rom_rise;        // First cycle of a ROM download
	logic hdr_end_wr;
	logic id_done_wr;

	assign rom_dl     = dl_active && (dl_index != CODE_INDEX);
	assign rom_rise   = rom_dl && !rom_dl_q;
	assign hdr_end_wr = rom_dl && dl_wr && (dl_addr == ADDR_HDR_END);
	assign id_done_wr = rom_dl && dl_wr && (dl_addr == ADDR_ID_DONE);

	always_ff @(posedge clk_sys) begin
		if (RESET)
			rom_dl_q <= 1'b0;
		else
			rom_dl_q <= rom_dl;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reset state and pulse widths

	a_reset_state: assert property (@(posedge clk_sys) $fell(RESET) |->
		!region_set && !code_valid && !code_clear && eeprom_map == '0 && sf_map == '0 &&
		!gun_type && rom_size == '0 && gun_sensor_delay == DEFAULT_SENSOR_DELAY)
	else begin
		$error("outputs not inactive after reset");
		violations++;
	end

	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
	else begin
		$error("code_valid longer than one cycle");
		violations++;
	end

	a_clear_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_clear |=> !code_clear)
	else begin
		$error("code_clear longer than one cycle");
		violations++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Result timing

	a_set_after_hdr: assert property (@(posedge clk_sys) disable iff (RESET)
		hdr_end_wr && auto_region_en |-> ##3 $rose(region_set))
	else begin
		$error("region_set did not rise 3 cycles after the 0x200 write");
		violations++;
	end

	a_set_cause: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(region_set) |-> $past(hdr_end_wr, 3))
	else begin
		$error("region_set rose without a 0x200 write 3 cycles earlier");
		violations++;
	end

	a_quirk_timing: assert property (@(posedge clk_sys) disable iff (RESET)
		$changed({eeprom_map, sf_map, gun_type, gun_sensor_delay}) |->
		$past(id_done_wr, 2) || $past(rom_rise, 2))
	else begin
		$error("quirk outputs changed outside their update slots");
		violations++;
	end

endmodule

bind cart_header_top cart_header_props #(
	.DEFAULT_SENSOR_DELAY (DEFAULT_SENSOR_DELAY)
) i_props (
	.clk_sys          (clk_sys),
	.RESET            (RESET),
	.dl_active        (dl_active),
	.dl_index         (dl_index),
	.dl_wr            (dl_wr),
	.dl_addr          (dl_addr),
	.auto_region_en   (auto_region_en),
	.region_set       (region_set),
	.rom_size         (rom_size),
	.eeprom_map       (eeprom_map),
	.sf_map           (sf_map),
	.gun_type         (gun_type),
	.gun_sensor_delay (gun_sensor_delay),
	.code_clear       (code_clear),
	.code_valid       (code_valid)
);

`default_nettype wire

// File: dv/tb_cart_header.sv
////////////////////////////////////////////////////////////////////////////
// Cartridge header testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_cart_header;
	import cart_pkg::*;
	import cheat_pkg::*;

	localparam int CLK_PERIOD    = 40;
	localparam int DELAY_DEFAULT = 44;
	localparam int ROM_DOWNLOADS = 32 + 16 + 1 + 9 + 1;
	localparam int ROM_WORDS_MAX = (16'h240 - 16'h180) / 2 + 1;
	localparam int CODE_WORDS    = 3 * 8 + 4;
	localparam int WORD_CYCLES   = 5;   // Write, idle and longest gap
	localparam int DL_OVERHEAD   = 32;  // Start, settle and result wait
	localparam int DL_CYCLES     = ROM_DOWNLOADS * (ROM_WORDS_MAX * WORD_CYCLES + DL_OVERHEAD)
		+ CODE_WORDS * WORD_CYCLES + DL_OVERHEAD;
	localparam longint WATCHDOG_NS = longint'(DL_CYCLES) * CLK_PERIOD * 3 / 2;

	logic          clk_sys = 1'b0;
	logic          RESET;
	logic          dl_active;
	logic [7:0]    dl_index;
	logic          dl_wr;
	dl_addr_t      dl_addr;
	dl_word_t      dl_data;
	region_prio_t  region_prio;
	logic          auto_region_en;
	region_t       region_req;
	logic          region_set;
	dl_addr_t      rom_size;
	eeprom_map_t   eeprom_map;
	sf_map_t       sf_map;
	logic          gun_type;
	sensor_delay_t gun_sensor_delay;
	logic          code_clear;
	logic          code_valid;
	cheat_word_t   code_flags;
	cheat_word_t   code_addr;
	cheat_word_t   code_compare;
	cheat_word_t   code_replace;

	logic [7:0]    img [0:1023];  // ROM byte image
	integer        seed = 29694;
	int            errors = 0;
	int            tests_run = 0;
	int            tests_failed = 0;
	dl_addr_t      last_rom_addr;
	int            set_count = 0;
	logic          set_prev = 1'b0;
	region_t       req_seen;
	int            clear_count = 0;
	cheat_word_t   cap_flags [$];
	cheat_word_t   cap_addr [$];
	cheat_word_t   cap_compare [$];
	cheat_word_t   cap_replace [$];

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	cart_header_top #(
		.DEFAULT_SENSOR_DELAY (8'(DELAY_DEFAULT))
	) i_dut (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.dl_active        (dl_active),
		.dl_index         (dl_index),
		.dl_wr            (dl_wr),
		.dl_addr          (dl_addr),
		.dl_data          (dl_data),
		.region_prio      (region_prio),
		.auto_region_en   (auto_region_en),
		.region_req       (region_req),
		.region_set       (region_set),
		.rom_size         (rom_size),
		.eeprom_map       (eeprom_map),
		.sf_map           (sf_map),
		.gun_type         (gun_type),
		.gun_sensor_delay (gun_sensor_delay),
		.code_clear       (code_clear),
		.code_valid       (code_valid),
		.code_flags       (code_flags),
		.code_addr        (code_addr),
		.code_compare     (code_compare),
		.code_replace     (code_replace)
	);

	// Output monitor on the falling edge
	always @(negedge clk_sys) begin
		if (region_set && !set_prev) begin
			set_count = set_count + 1;
			req_seen  = region_req;  // Region at the rising edge of region_set
		end
		set_prev = region_set;
		if (code_clear)
			clear_count = clear_count + 1;
		if (code_valid) begin
			cap_flags.push_back(code_flags);
			cap_addr.push_back(code_addr);
			cap_compare.push_back(code_compare);
			cap_replace.push_back(code_replace);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the downloads did not finish in the expected time");
		$display("Test FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference rules

	function automatic region_t expected_region(input region_prio_t prio, input logic [2:0] euj);
		region_t order [0:2];
		logic    present;
		case (prio)
			2'd0:    order = '{US, EU, JP};
			2'd1:    order = '{EU, US, JP};
			2'd2:    order = '{US, JP, EU};
			default: order = '{JP, US, EU};
		endcase
		expected_region = order[0];  // Nothing flagged
		for (int i = 2; i >= 0; i--) begin
			present = (order[i] == JP) ? euj[0] : (order[i] == US) ? euj[1] : euj[2];
			if (present)
				expected_region = order[i];
		end
	endfunction

	// Hex digit value bits 3, 2 and 0 give E, U and J
	function automatic logic [2:0] digit_flags(input int value);
		logic [3:0] v;
		v = 4'(value);
		digit_flags = {v[3], v[2], v[0]};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic check_value(input logic ok, input string what);
		assert (ok)
		else begin
			$display("ERR %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic set_header(input logic [87:0] serial, input logic [15:0] crc,
			input logic [7:0] rgn_a, input logic [7:0] rgn_b, input logic [7:0] rgn_c);
		for (int a = 0; a < 1024; a++)
			img[a] = 8'(a ^ (a >> 3));  // Address dependent filler
		for (int i = 0; i < 11; i++)
			img[16'h180 + i] = serial[87 - 8 * i -: 8];
		img[16'h18E] = crc[15:8];
		img[16'h18F] = crc[7:0];
		img[16'h1F0] = rgn_a;
		img[16'h1F1] = rgn_b;
		img[16'h1F2] = rgn_c;
	endtask

	task automatic write_word(input dl_addr_t addr, input dl_word_t data);
		int gap;
		gap = $unsigned($random(seed)) % 4;
		@(posedge clk_sys);
		dl_wr   <= 1'b1;
		dl_addr <= addr;
		dl_data <= data;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		repeat (gap) @(posedge clk_sys);
	endtask

	task automatic rom_download;
		last_rom_addr = 25'h202 + 2 * ($unsigned($random(seed)) % 32);
		@(posedge clk_sys);
		dl_index  <= 8'h00;
		dl_active <= 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value(eeprom_map == 0 && sf_map == 0 && gun_type == 0
			&& gun_sensor_delay == DELAY_DEFAULT, "quirk outputs not cleared at download start");
		for (int a = 16'h180; a <= last_rom_addr; a += 2)
			write_word(dl_addr_t'(a), {img[a + 1], img[a]});  // Even byte in the low half
		@(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value(rom_size == last_rom_addr,
			$sformatf("rom_size %h, expected %h", rom_size, last_rom_addr));
	endtask

	task automatic await_region_set(input int target);
		int n;
		n = 0;
		while (set_count < target && n < 16) begin
			@(negedge clk_sys);
			n++;
		end
		if (set_count < target) begin
			$display("region_set did not rise after the header was written");
			errors++;
		end
	endtask

	task automatic region_case(input int prio, input logic [7:0] rgn_a,
			input logic [7:0] rgn_b, input logic [7:0] rgn_c, input logic [2:0] euj);
		int base;
		@(posedge clk_sys);
		region_prio <= region_prio_t'(prio);
		set_header("GM 00000000", 16'h0000, rgn_a, rgn_b, rgn_c);
		base = set_count;
		rom_download();
		await_region_set(base + 1);
		check_value(req_seen == expected_region(region_prio_t'(prio), euj),
			$sformatf("prio %0d flags %b gave region %0d", prio, euj, req_seen));
	endtask

	task automatic quirk_case(input logic [87:0] serial, input logic [15:0] crc,
			input int eep, input int sf, input int gun, input int delay);
		set_header(serial, crc, "J", " ", " ");
		rom_download();
		check_value(eeprom_map == eep && sf_map == sf && gun_type == gun
			&& gun_sensor_delay == delay, $sformatf("serial %s gave quirks %0d %0d %0d %0d",
			serial, eeprom_map, sf_map, gun_type, gun_sensor_delay));
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors > err_before) begin
			tests_failed++;
			$display("%s: failed", name);
		end else begin
			$display("%s: passed", name);
		end
	endtask

	task automatic cheat_records;
		cheat_word_t rec [0:2][0:3];  // Flags, address, compare, replace
		dl_addr_t    hdr_addr [0:3];
		dl_addr_t    size_before;
		region_t     req_before;
		int          sets_before;
		size_before = rom_size;
		req_before  = region_req;
		sets_before = set_count;
		hdr_addr    = '{ADDR_ID4, ADDR_ID_DONE, ADDR_RGN0, ADDR_HDR_END};
		for (int r = 0; r < 3; r++) begin
			for (int k = 0; k < 4; k++)
				rec[r][k] = $random(seed);
			rec[r][1][31] = (r == 1);  // Second record disabled
		end
		@(posedge clk_sys);
		dl_index  <= CODE_INDEX;
		dl_active <= 1'b1;
		for (int r = 0; r < 3; r++) begin
			for (int k = 0; k < 4; k++) begin
				write_word(dl_addr_t'(r * 16 + k * 4), rec[r][k][15:0]);
				write_word(dl_addr_t'(r * 16 + k * 4 + 2), rec[r][k][31:16]);
			end
		end
		// Header addresses under the code index
		for (int i = 0; i < 4; i++)
			write_word(hdr_addr[i], 16'h0000);
		@(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value(cap_addr.size() == 2, $sformatf("%0d code_valid pulses", cap_addr.size()));
		if (cap_addr.size() == 2) begin
			for (int j = 0; j < 2; j++) begin
				check_value(cap_flags[j] == rec[2 * j][0] && cap_addr[j] == rec[2 * j][1]
					&& cap_compare[j] == rec[2 * j][2] && cap_replace[j] == rec[2 * j][3],
					$sformatf("code %0d fields %h %h %h %h", j, cap_flags[j], cap_addr[j],
					cap_compare[j], cap_replace[j]));
			end
		end
		check_value(clear_count == 1, $sformatf("%0d code_clear pulses", clear_count));
		check_value(rom_size == size_before, "code download changed rom_size");
		check_value(set_count == sets_before && !region_set && region_req == req_before,
			"code download changed the region outputs");
		check_value(gun_type == 1 && gun_sensor_delay == 52 && eeprom_map == 0 && sf_map == 0,
			"code download changed the quirk outputs");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [7:0] slot [0:2];
		logic [7:0] letter [0:2];
		logic [7:0] ch;
		int         err_before;
		RESET          = 1'b1;
		dl_active      = 1'b0;
		dl_index       = 8'h00;
		dl_wr          = 1'b0;
		dl_addr        = '0;
		dl_data        = '0;
		region_prio    = 2'd0;
		auto_region_en = 1'b1;
		letter         = '{"J", "U", "E"};
		repeat (2) @(posedge clk_sys);
		RESET <= 1'b0;

		err_before = errors;
		for (int p = 0; p < 4; p++) begin
			for (int m = 0; m < 8; m++) begin
				for (int i = 0; i < 3; i++)
					slot[(i + p) % 3] = m[i] ? letter[i] : " ";  // Letter slots rotate
				region_case(p, slot[0], slot[1], slot[2], 3'(m));
			end
		end
		finish_test("letter_headers", err_before);

		err_before = errors;
		for (int v = 0; v < 16; v++) begin
			ch = (v < 10) ? 8'(8'h30 + v) : 8'(8'h41 + v - 10);
			case (v % 4)
				0: region_case(v / 4, ch, " ", " ", digit_flags(v));
				1: region_case(v / 4, ch, " ", "J", digit_flags(v) | 3'b001);
				2: region_case(v / 4, ch, " ", "U", digit_flags(v) | 3'b010);
				default: region_case(v / 4, ch, " ", "E", digit_flags(v) | 3'b100);
			endcase
		end
		finish_test("digit_headers", err_before);

		err_before = errors;
		@(posedge clk_sys);
		auto_region_en <= 1'b0;
		set_header("GM 00000000", 16'h0000, "U", "E", "J");
		begin
			int base;
			base = set_count;
			rom_download();
			check_value(set_count == base && !region_set, "region_set rose with auto region off");
		end
		@(posedge clk_sys);
		auto_region_en <= 1'b1;
		finish_test("auto_region_off", err_before);

		err_before = errors;
		quirk_case("GM T-50446 ", 16'h0000, 1, 0, 0, DELAY_DEFAULT);
		quirk_case("GM MK-1215 ", 16'h0000, 2, 0, 0, DELAY_DEFAULT);
		quirk_case("GM T-081326", 16'h0000, 3, 0, 0, DELAY_DEFAULT);
		quirk_case("SF-001     ", 16'h3E08, 0, 1 + 4, 0, DELAY_DEFAULT);
		quirk_case("SF-001     ", 16'h1234, 0, 1, 0, DELAY_DEFAULT);
		quirk_case("SF-002     ", 16'h0000, 0, 6, 0, DELAY_DEFAULT);
		quirk_case("GM T-95096-", 16'h0000, 0, 0, 1, 52);
		quirk_case("GM MK-1533 ", 16'h0000, 0, 0, 0, 100);
		quirk_case("GM T-12345 ", 16'h0000, 0, 0, 0, DELAY_DEFAULT);
		finish_test("quirk_table", err_before);

		err_before = errors;
		quirk_case("GM T-95096-", 16'h0000, 0, 0, 1, 52);
		finish_test("rom_size", err_before);

		err_before = errors;
		cheat_records();
		finish_test("cheat_records", err_before);

		errors = errors + i_dut.i_props.violations;
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
common/cart_pkg.sv
common/cheat_pkg.sv
design/dl_capture.sv
header/region_decode.sv
header/cart_id_match.sv
design/cheat_loader.sv
design/cart_header_top.sv
dv/cart_header_props.sv
dv/tb_cart_header.sv

// File: Bender.yml
package:
  name: cart_header

sources:
  # Packages first, then RTL in dependency order
  - common/cart_pkg.sv
  - common/cheat_pkg.sv
  - design/dl_capture.sv
  - header/region_decode.sv
  - header/cart_id_match.sv
  - design/cheat_loader.sv
  - design/cart_header_top.sv

  # Testbench sources
  - target: test
    files:
      - dv/cart_header_props.sv
      - dv/tb_cart_header.sv
